// ==== adc_acq.sv ====
`timescale 1ns/1ps

module adc_acq import wfd_pkg::*; #(
	parameter int BUF_ADDR_W = 9
) (
	input  logic                  clk50,
	input  logic                  rst,
	input  acq_cfg_t              cfg,
	input  logic                  fill_num_load,
	input  logic [FILL_NUM_W-1:0] fill_num_init,
	output logic [FILL_NUM_W-1:0] fill_num,
	input  logic [CH_ADDR_W-1:0]  ch_addr,
	input  fill_type_t            acq_enable,
	input  logic                  acq_trig,
	input  logic [SAMPLE_W-1:0]   adc_data,
	input  logic                  adc_ovr,
	input  logic                  fill_held,
	output buf_wr_t               buf_wr,
	output logic                  fill_end,         // sets fill_held in the buffer
	output logic                  acq_done,
	output logic                  led1,             // red, active low
	output logic                  led2              // green, active low
);

	localparam int LANE_CNT_W = $clog2(LANES);
	localparam logic [LANE_CNT_W-1:0] LANE_LAST = LANE_CNT_W'(LANES - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,                                  // header on the write port
		ST_SAMPLING
	} acq_state_t;

	acq_state_t            state;
	logic [BURST_W-1:0]    sel_bursts;              // count for the enabled fill type
	logic [BURST_W-1:0]    bursts_left;             // bursts still to collect
	logic [LANE_CNT_W-1:0] lane_cnt;
	logic                  wr_en;
	logic                  wr_last;                 // write port holds the last word
	logic [BUF_ADDR_W-1:0] wr_addr;
	fill_word_u            wr_word;
	burst_t                shreg;                   // samples shift in from the top
	logic [LANE_W-1:0]     new_lane;
	fill_header_t          hdr;
	logic                  accept;
	logic                  sampling;
	logic                  burst_full;
	logic                  fill_over;               // last word written this edge

	always_comb begin
		case (acq_enable)
			FILL_MUON:  sel_bursts = cfg.muon_bursts;
			FILL_LASER: sel_bursts = cfg.laser_bursts;
			FILL_PED:   sel_bursts = cfg.ped_bursts;
			default:    sel_bursts = '0;
		endcase
	end

	// fill_end covers the edge before fill_held rises
	assign accept     = (state == ST_IDLE) && acq_trig && (acq_enable != FILL_NONE)
		&& !fill_held && !fill_end;
	assign sampling   = (state != ST_IDLE) && (bursts_left != '0);
	assign burst_full = sampling && (lane_cnt == LANE_LAST);
	assign fill_over  = wr_en && wr_last;
	assign new_lane   = {adc_ovr, {(LANE_W - SAMPLE_W - 1){1'b0}}, adc_data};

	always_comb begin
		hdr             = '0;
		hdr.mark        = HEADER_MARK;
		hdr.ch_addr     = ch_addr;
		hdr.fill_type   = acq_enable;
		hdr.burst_cnt   = sel_bursts;
		hdr.channel_tag = cfg.channel_tag;
		hdr.fill_num    = fill_num;                 // number before this fill's increment
	end

	////////////////////////////////////////////////////////////
	// control

	always_ff @(posedge clk50) begin
		if (rst) begin
			state       <= ST_IDLE;
			bursts_left <= '0;
			lane_cnt    <= '0;
			wr_en       <= 1'b0;
			wr_last     <= 1'b0;
			acq_done    <= 1'b0;
			fill_num    <= '0;
		end else begin
			wr_en    <= 1'b0;
			acq_done <= fill_over;                  // edge after the last write
			if (fill_num_load)
				fill_num <= fill_num_init;          // preload wins
			else if (fill_over)
				fill_num <= fill_num + 1'b1;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state       <= ST_HEADER;
						bursts_left <= sel_bursts;
						lane_cnt    <= '0;
						wr_en       <= 1'b1;        // header goes out first
						wr_last     <= (sel_bursts == '0);
					end
				end
				ST_HEADER, ST_SAMPLING: begin
					state <= fill_over ? ST_IDLE : ST_SAMPLING;
					if (sampling) begin
						lane_cnt <= lane_cnt + 1'b1;    // wraps after the eighth lane
						if (burst_full) begin
							wr_en       <= 1'b1;
							wr_last     <= (bursts_left == 1);
							bursts_left <= bursts_left - 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// data path

	always_ff @(posedge clk50) begin
		if (accept) begin
			wr_addr     <= '0;
			wr_word.hdr <= hdr;
		end else if (burst_full) begin
			wr_addr       <= wr_addr + 1'b1;        // burst b lands at b+1
			wr_word.burst <= {new_lane, shreg[LANES-1:1]};
		end
		if (sampling)
			shreg <= {new_lane, shreg[LANES-1:1]};  // oldest ends in lane 0
	end

	always_comb begin
		buf_wr.en   = wr_en;
		buf_wr.addr = FILL_ADDR_W'(wr_addr);
		buf_wr.data = wr_word;
	end

	assign fill_end = acq_done;

	// led: orange while acquiring, red while a fill waits, else green
	always_comb begin
		if (state != ST_IDLE)
			{led1, led2} = 2'b00;
		else if (fill_held || acq_done)
			{led1, led2} = 2'b01;
		else
			{led1, led2} = 2'b10;
	end

endmodule

// ==== build.f ====
wfd_pkg.sv
chan_regs.sv
adc_acq.sv
fill_buffer.sv
fill_readout.sv
channel_main.sv
channel_properties.sv
tb_channel.sv

// ==== chan_regs.sv ====
`timescale 1ns/1ps

module chan_regs import wfd_pkg::*; (
	input  logic                  clk50,
	input  logic                  rst,
	input  logic                  reg_wr,           // write strobe
	input  logic [3:0]            reg_addr,
	input  logic [31:0]           reg_wdata,
	output logic [31:0]           reg_rdata,        // combinational readback
	input  logic [FILL_NUM_W-1:0] fill_num,         // live fill number
	output acq_cfg_t              cfg,
	output logic                  fill_num_load,    // one cycle, with the write
	output logic [FILL_NUM_W-1:0] fill_num_init
);

	// register map
	localparam logic [3:0] REG_TAG   = 4'd0;
	localparam logic [3:0] REG_MUON  = 4'd1;
	localparam logic [3:0] REG_LASER = 4'd2;
	localparam logic [3:0] REG_PED   = 4'd3;
	localparam logic [3:0] REG_FILL  = 4'd4;        // write loads, read returns fill_num

	////////////////////////////////////////////////////////////
	// write decode

	always_ff @(posedge clk50) begin
		if (rst) begin
			cfg <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				REG_TAG:   cfg.channel_tag  <= reg_wdata[TAG_W-1:0];
				REG_MUON:  cfg.muon_bursts  <= reg_wdata[BURST_W-1:0];
				REG_LASER: cfg.laser_bursts <= reg_wdata[BURST_W-1:0];
				REG_PED:   cfg.ped_bursts   <= reg_wdata[BURST_W-1:0];
				default: ;                          // fill number handled below
			endcase
		end
	end

	// initial fill number is not stored here, the counter in adc_acq takes it
	assign fill_num_load = reg_wr && (reg_addr == REG_FILL);
	assign fill_num_init = reg_wdata[FILL_NUM_W-1:0];

	////////////////////////////////////////////////////////////
	// readback

	always_comb begin
		case (reg_addr)
			REG_TAG:   reg_rdata = 32'(cfg.channel_tag);
			REG_MUON:  reg_rdata = 32'(cfg.muon_bursts);
			REG_LASER: reg_rdata = 32'(cfg.laser_bursts);
			REG_PED:   reg_rdata = 32'(cfg.ped_bursts);
			REG_FILL:  reg_rdata = 32'(fill_num);
			default:   reg_rdata = '0;              // unmapped
		endcase
	end

endmodule

// ==== channel_main.sv ====
`timescale 1ns/1ps

module channel_main import wfd_pkg::*; #(
	parameter int BUF_ADDR_W = 9                    // buffer depth is 2**BUF_ADDR_W words
) (
	input  logic                  clk50,            // system clock
	input  logic                  rst,              // sync, active high
	// register port from the master
	input  logic                  reg_wr,
	input  logic [3:0]            reg_addr,
	input  logic [31:0]           reg_wdata,
	output logic [31:0]           reg_rdata,
	// acquisition control
	input  logic [CH_ADDR_W-1:0]  ch_addr,          // this chip's address, from jumpers
	input  fill_type_t            acq_enable,       // enabled for triggers, and fill type
	input  logic                  acq_trig,         // start of a fill
	input  logic [SAMPLE_W-1:0]   adc_data,         // one sample per clock
	input  logic                  adc_ovr,          // over-range
	output logic                  acq_done,         // end of acquisition pulse
	// fill stream to the master
	input  logic                  readout_pause,
	input  logic                  tx_ready,
	output logic [TX_W-1:0]       tx_data,
	output logic [TX_W/8-1:0]     tx_keep,
	output logic                  tx_valid,
	output logic                  tx_last,
	// front panel led, active low
	output logic                  led1,             // red
	output logic                  led2              // green
);

	acq_cfg_t              cfg;                     // tag and burst counts
	logic                  fill_num_load;           // preload strobe
	logic [FILL_NUM_W-1:0] fill_num_init;
	logic [FILL_NUM_W-1:0] fill_num;                // current fill number
	buf_wr_t               buf_wr;
	logic                  fill_end;
	logic                  fill_held;               // one fill in the buffer
	logic                  fill_release;
	logic [BUF_ADDR_W-1:0] rd_addr;
	fill_word_u            rd_data;

	////////////////////////////////////////////////////////////
	// configuration registers

	chan_regs chan_regs (
		.clk50(clk50),
		.rst(rst),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.fill_num(fill_num),                        // for readback
		.cfg(cfg),
		.fill_num_load(fill_num_load),
		.fill_num_init(fill_num_init)
	);

	////////////////////////////////////////////////////////////
	// acquisition into the fill buffer

	adc_acq #(
		.BUF_ADDR_W(BUF_ADDR_W)
	) adc_acq (
		.clk50(clk50),
		.rst(rst),
		.cfg(cfg),
		.fill_num_load(fill_num_load),
		.fill_num_init(fill_num_init),
		.fill_num(fill_num),
		.ch_addr(ch_addr),
		.acq_enable(acq_enable),
		.acq_trig(acq_trig),
		.adc_data(adc_data),
		.adc_ovr(adc_ovr),
		.fill_held(fill_held),                      // blocks a new trigger
		.buf_wr(buf_wr),
		.fill_end(fill_end),
		.acq_done(acq_done),
		.led1(led1),
		.led2(led2)
	);

	fill_buffer #(
		.BUF_ADDR_W(BUF_ADDR_W)
	) fill_buffer (
		.clk50(clk50),
		.rst(rst),
		.buf_wr(buf_wr),
		.fill_end(fill_end),                        // sets fill_held
		.fill_release(fill_release),                // clears fill_held
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.fill_held(fill_held)
	);

	////////////////////////////////////////////////////////////
	// readout onto the transmit stream

	fill_readout #(
		.BUF_ADDR_W(BUF_ADDR_W)
	) fill_readout (
		.clk50(clk50),
		.rst(rst),
		.fill_held(fill_held),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.readout_pause(readout_pause),
		.tx_ready(tx_ready),
		.tx_data(tx_data),
		.tx_keep(tx_keep),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.fill_release(fill_release)
	);

endmodule

// ==== channel_properties.sv ====
`timescale 1ns/1ps

module channel_properties import wfd_pkg::*; (
	input logic            clk50,
	input logic            rst,
	input logic [TX_W-1:0] tx_data,
	input logic            tx_valid,
	input logic            tx_ready,
	input logic            tx_last,
	input logic            acq_done
);

	////////////////////////////////////////////////////////////
	// transmit stream

	// a stalled word holds its data and framing
	tx_stable: assert property (@(posedge clk50) disable iff (rst)
		tx_valid && !tx_ready |=> $stable(tx_data) && $stable(tx_last))
		else $error("tx_data or tx_last changed while stalled");

	// nothing valid right after reset
	tx_reset: assert property (@(posedge clk50)
		rst |=> !tx_valid)
		else $error("tx_valid high after reset");

	////////////////////////////////////////////////////////////
	// acquisition

	done_pulse: assert property (@(posedge clk50) disable iff (rst)
		acq_done |=> !acq_done)
		else $error("acq_done high two cycles running");

endmodule

bind channel_main channel_properties props_i (
	.clk50(clk50),
	.rst(rst),
	.tx_data(tx_data),
	.tx_valid(tx_valid),
	.tx_ready(tx_ready),
	.tx_last(tx_last),
	.acq_done(acq_done)
);

// ==== fill_buffer.sv ====
`timescale 1ns/1ps

module fill_buffer import wfd_pkg::*; #(
	parameter int BUF_ADDR_W = 9
) (
	input  logic                  clk50,
	input  logic                  rst,
	input  buf_wr_t               buf_wr,           // from acquisition
	input  logic                  fill_end,
	input  logic                  fill_release,
	input  logic [BUF_ADDR_W-1:0] rd_addr,
	output fill_word_u            rd_data,          // one cycle after rd_addr
	output logic                  fill_held         // a complete fill waits for readout
);

	localparam int DEPTH = 2 ** BUF_ADDR_W;

	fill_word_u            mem [0:DEPTH-1];         // stands in for the ddr3
	logic [BUF_ADDR_W-1:0] wr_addr;

	assign wr_addr = BUF_ADDR_W'(buf_wr.addr);

	////////////////////////////////////////////////////////////
	// memory, one write port and one registered read port

	always_ff @(posedge clk50) begin
		if (buf_wr.en)
			mem[wr_addr] <= buf_wr.data;
		rd_data <= mem[rd_addr];
	end

	// single fill buffer, so the header fifo shrinks to one flag
	always_ff @(posedge clk50) begin
		if (rst)
			fill_held <= 1'b0;
		else if (fill_end)
			fill_held <= 1'b1;
		else if (fill_release)
			fill_held <= 1'b0;                      // readout finished
	end

endmodule

// ==== fill_readout.sv ====
`timescale 1ns/1ps

module fill_readout import wfd_pkg::*; #(
	parameter int BUF_ADDR_W = 9
) (
	input  logic                  clk50,
	input  logic                  rst,
	input  logic                  fill_held,
	output logic [BUF_ADDR_W-1:0] rd_addr,
	input  fill_word_u            rd_data,
	input  logic                  readout_pause,    // hold off new words
	input  logic                  tx_ready,
	output logic [TX_W-1:0]       tx_data,
	output logic [TX_W/8-1:0]     tx_keep,
	output logic                  tx_valid,
	output logic                  tx_last,
	output logic                  fill_release      // pulse after the last handshake
);

	localparam int QUARTERS = WORD_W / TX_W;
	localparam int QW       = $clog2(QUARTERS);
	localparam logic [QW-1:0] Q_LAST = QW'(QUARTERS - 1);
	localparam logic [QW-1:0] Q_PREV = QW'(QUARTERS - 2);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,                                   // address out, data next cycle
		RD_LOAD,                                    // rd_data valid, wait for no pause
		RD_SEND
	} rd_state_t;

	rd_state_t             state;
	logic [WORD_W-1:0]     shreg;                   // word being sent, low quarter first
	logic [QW-1:0]         qcnt;                    // quarter on tx_data
	logic [BUF_ADDR_W-1:0] cur_word;                // address of the word in shreg
	logic [BUF_ADDR_W-1:0] last_word;               // burst count from the header
	logic                  load_word;
	logic                  tx_hs;

	assign tx_hs     = tx_valid && tx_ready;
	assign load_word = (state == RD_LOAD) && !readout_pause;
	assign tx_data   = shreg[TX_W-1:0];
	assign tx_keep   = '1;

	////////////////////////////////////////////////////////////
	// sequencing

	always_ff @(posedge clk50) begin
		if (rst) begin
			state        <= RD_IDLE;
			rd_addr      <= '0;
			qcnt         <= '0;
			cur_word     <= '0;
			last_word    <= '0;
			tx_valid     <= 1'b0;
			tx_last      <= 1'b0;
			fill_release <= 1'b0;
		end else begin
			fill_release <= 1'b0;
			case (state)
				RD_IDLE: begin
					// fill_held still high on the edge of the release pulse
					if (fill_held && !fill_release)
						state <= RD_FETCH;
				end
				RD_FETCH: state <= RD_LOAD;
				RD_LOAD: begin
					if (!readout_pause) begin
						state    <= RD_SEND;
						tx_valid <= 1'b1;
						tx_last  <= 1'b0;
						qcnt     <= '0;
						cur_word <= rd_addr;
						if (rd_addr == '0)
							last_word <= BUF_ADDR_W'(rd_data.hdr.burst_cnt);
					end
				end
				RD_SEND: begin
					if (tx_hs) begin
						if (tx_last) begin
							state        <= RD_IDLE;
							tx_valid     <= 1'b0;
							tx_last      <= 1'b0;
							rd_addr      <= '0;     // ready for the next header
							fill_release <= 1'b1;
						end else if (qcnt == Q_LAST) begin
							state    <= RD_LOAD;
							tx_valid <= 1'b0;
						end else begin
							qcnt     <= qcnt + 1'b1;
							tx_valid <= !readout_pause;
							tx_last  <= (qcnt == Q_PREV) && (cur_word == last_word);
							if (qcnt == Q_PREV)
								rd_addr <= cur_word + 1'b1;  // fetch under the last quarter
						end
					end else if (!tx_valid && !readout_pause) begin
						tx_valid <= 1'b1;           // pause lifted
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// 128 to 32 bit serialiser

	always_ff @(posedge clk50) begin
		if (load_word)
			shreg <= rd_data;
		else if (tx_hs)
			shreg <= {{TX_W{1'b0}}, shreg[WORD_W-1:TX_W]};
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator and run the channel testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_channel -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^sim passed$" sim.log; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

// ==== tb_channel.sv ====
`timescale 1ns/1ps

module tb_channel import wfd_pkg::*; ;

	localparam int BUF_ADDR_W = 9;
	localparam int NFILLS     = 12;
	localparam int MAX_N      = 24;                 // largest random burst count
	// every fill at full length plus margin for random back-pressure
	localparam longint WD_NS  = longint'(NFILLS + 4) * (8 * 255 + 4 * 256 + 50) * 8 * 3;

	logic            clk50;
	logic            rst;
	logic            reg_wr;
	logic [3:0]      reg_addr;
	logic [31:0]     reg_wdata;
	logic [31:0]     reg_rdata;
	logic [2:0]      ch_addr;
	fill_type_t      acq_enable;
	logic            acq_trig;
	logic [11:0]     adc_data;
	logic            adc_ovr;
	logic            readout_pause;
	logic            tx_ready;
	logic [31:0]     tx_data;
	logic [3:0]      tx_keep;
	logic            tx_valid;
	logic            tx_last;
	logic            acq_done;
	logic            led1;
	logic            led2;

	integer          seed = 43047;
	integer          seed_bp = 43047 + 1;       // back-pressure stream
	logic            hold_pause;
	int              done_cnt;
	int              test_err;
	int              total_err;
	int              tests;
	logic [23:0]     fill_model;                // expected fill number
	logic [31:0]     rx_data [$];
	logic            rx_last [$];

	channel_main #(.BUF_ADDR_W(BUF_ADDR_W)) dut_i (.*);

	initial begin
		clk50 = 1'b0;
		forever #4 clk50 = ~clk50;
	end

	initial begin
		#(WD_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

	// random tx_ready and readout_pause unless hold_pause forces the pause
	initial begin
		tx_ready      = 1'b0;
		readout_pause = 1'b0;
		forever begin
			@(negedge clk50);
			tx_ready      = ($random(seed_bp) % 3) != 0;
			readout_pause = hold_pause || (($random(seed_bp) % 5) == 0);
		end
	end

	// outputs sampled at the rising edge while inputs move on the falling one
	always @(posedge clk50) begin
		if (!rst) begin
			if (acq_done)
				done_cnt++;
			if (tx_valid && tx_ready) begin
				rx_data.push_back(tx_data);
				rx_last.push_back(tx_last);
				check_val("tx_keep", 4'hf, tx_keep);    // every byte lane carries data
			end
		end
	end

	task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
		if (exp !== got) begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			test_err++;
		end
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
		@(negedge clk50);
		reg_wr    = 1'b1;
		reg_addr  = a;
		reg_wdata = d;
		@(negedge clk50);
		reg_wr    = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] a, output logic [31:0] d);
		reg_addr = a;
		#1;
		d = reg_rdata;                              // combinational readback
	endtask

	function automatic logic [127:0] make_header(input logic [1:0] ft, input logic [7:0] n,
		input logic [15:0] tag, input logic [23:0] num, input logic [2:0] ch);
		logic [127:0] h;
		h          = '0;
		h[127:112] = 16'ha5f1;                      // header marker
		h[52:50]   = ch;
		h[49:48]   = ft;
		h[47:40]   = n;
		h[39:24]   = tag;
		h[23:0]    = num;
		return h;
	endfunction

	////////////////////////////////////////////////////////////
	// one fill from trigger through acq_done timing and stream contents

	task automatic run_fill(input logic [1:0] ft, input int n, input logic hold);
		logic [15:0]  tag;
		logic [15:0]  lanes [$];
		logic [127:0] exp_words [$];
		logic [127:0] w;
		int           edges;
		int           done_before;
		int           total;
		tag = $random(seed);
		write_reg(4'd0, 32'(tag));
		write_reg(4'(ft), 32'(n));                  // burst register address equals type code
		done_before = done_cnt;
		rx_data.delete();
		rx_last.delete();
		hold_pause  = hold;
		acq_enable  = fill_type_t'(ft);
		acq_trig    = 1'b1;
		@(posedge clk50);                           // accepting edge
		edges = 1;
		@(negedge clk50);
		check_val("led", 2'b00, {led1, led2});      // orange
		for (int i = 0; i < 8 * n; i++) begin
			adc_data = $random(seed);
			adc_ovr  = $random(seed);
			lanes.push_back({adc_ovr, 3'b000, adc_data});
			acq_trig = ($random(seed) % 4) == 0;    // retriggers are ignored
			@(posedge clk50);
			edges++;
			@(negedge clk50);
			if (acq_done) begin
				$display("acq_done came before the last burst was in");
				test_err++;
			end
		end
		acq_trig = 1'b0;
		while (!acq_done && edges < 8 * n + 10) begin
			@(posedge clk50);
			edges++;
			@(negedge clk50);
		end
		check_val("acq_done_cycles", 128'(8 * n + 2), 128'(edges));
		check_val("led", 2'b01, {led1, led2});      // red
		if (hold) begin
			// triggers must be refused while the buffer is full and readout stalled
			repeat (4) begin
				acq_trig = 1'b1;
				@(negedge clk50);
			end
			acq_trig = 1'b0;
			repeat (20) @(negedge clk50);
			check_val("acq_done_count", 128'(done_before + 1), 128'(done_cnt));
			check_val("led", 2'b01, {led1, led2});
			if (rx_data.size() != 0) begin
				$display("stream started while readout_pause was held");
				test_err++;
			end
			hold_pause = 1'b0;
		end
		exp_words.push_back(make_header(ft, 8'(n), tag, fill_model, ch_addr));
		for (int b = 0; b < n; b++) begin
			for (int l = 0; l < 8; l++)
				w[16*l +: 16] = lanes[8*b + l];
			exp_words.push_back(w);
		end
		total = 4 * (n + 1);
		edges = 0;
		while (rx_data.size() < total && edges < total * 50 + 200) begin
			@(posedge clk50);
			edges++;
		end
		repeat (10) @(negedge clk50);               // catch extra words
		if (rx_data.size() != total) begin
			$display("stream carried %0d words instead of %0d", rx_data.size(), total);
			test_err++;
		end else begin
			for (int j = 0; j < total; j++) begin
				check_val("tx_data", 128'(exp_words[j/4][32*(j%4) +: 32]), 128'(rx_data[j]));
				check_val("tx_last", 128'(j == total - 1), 128'(rx_last[j]));
			end
		end
		check_val("acq_done_count", 128'(done_before + 1), 128'(done_cnt));
		check_val("led", 2'b10, {led1, led2});      // green again
		fill_model = fill_model + 1'b1;
	endtask

	task automatic report(input string name);
		tests++;
		total_err += test_err;
		$display("test %s: %s (%0d errors)", name, (test_err == 0) ? "ok" : "FAIL", test_err);
		test_err = 0;
	endtask

	initial begin
		logic [3:0]  a;
		logic [31:0] d;
		logic [31:0] got;
		logic [31:0] mask;
		logic [1:0]  ft;
		int          n;
		rst        = 1'b1;
		reg_wr     = 1'b0;
		reg_addr   = '0;
		reg_wdata  = '0;
		ch_addr    = $random(seed);
		acq_enable = FILL_NONE;
		acq_trig   = 1'b0;
		adc_data   = '0;
		adc_ovr    = 1'b0;
		hold_pause = 1'b0;
		done_cnt   = 0;
		test_err   = 0;
		total_err  = 0;
		tests      = 0;
		repeat (2) @(posedge clk50);
		@(negedge clk50);
		rst = 1'b0;
		check_val("led", 2'b10, {led1, led2});
		check_val("tx_valid", 1'b0, tx_valid);
		check_val("acq_done", 1'b0, acq_done);
		report("reset");

		for (int k = 0; k < 8; k++) begin
			a    = 4'($unsigned($random(seed)) % 4);
			d    = $random(seed);
			mask = (a == 0) ? 32'h0000_ffff : 32'h0000_00ff;
			write_reg(a, d);
			read_reg(a, got);
			check_val("reg_rdata", d & mask, got);
		end
		d = $random(seed);
		write_reg(4'd4, d);
		read_reg(4'd4, got);
		check_val("reg_rdata", d & 32'h00ff_ffff, got);
		fill_model = d[23:0];
		report("registers");

		acq_enable = FILL_NONE;
		repeat (5) begin
			acq_trig = 1'b1;
			@(negedge clk50);
		end
		acq_trig = 1'b0;
		repeat (30) @(negedge clk50);
		check_val("acq_done_count", 0, done_cnt);
		check_val("rx_words", 0, rx_data.size());
		check_val("led", 2'b10, {led1, led2});
		report("trigger_disabled");

		for (int k = 0; k < NFILLS; k++) begin
			ft = 2'(1 + $unsigned($random(seed)) % 3);
			n  = (k == 0) ? 0 : $unsigned($random(seed)) % MAX_N;
			if (k == 6) begin
				d = $random(seed);                  // restart the numbering
				write_reg(4'd4, d);
				fill_model = d[23:0];
			end
			run_fill(ft, n, k == 3);
			report($sformatf("fill%0d_type%0d_bursts%0d", k, ft, n));
		end

		$display("tests %0d, errors %0d", tests, total_err);
		if (total_err == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== wfd_pkg.sv ====
package wfd_pkg;

	////////////////////////////////////////////////////////////
	// widths

	localparam int SAMPLE_W   = 12;                 // adc sample
	localparam int LANES      = 8;                  // samples per burst
	localparam int LANE_W     = 16;                 // ovr flag, 3 zero bits, sample
	localparam int WORD_W     = 128;                // buffer word
	localparam int TX_W       = 32;                 // transmit word
	localparam int BURST_W    = 8;                  // burst count registers
	localparam int FILL_NUM_W = 24;                 // fill number
	localparam int TAG_W      = 16;                 // channel tag
	localparam int CH_ADDR_W  = 3;                  // channel address jumpers
	localparam int MARK_W     = 16;                 // header marker

	// address field of the write port, header plus the largest burst count
	localparam int FILL_ADDR_W = BURST_W + 1;

	localparam logic [MARK_W-1:0] HEADER_MARK = 16'ha5f1;  // top bits of every header

	// fill type, same encoding as the acq_enable pins
	typedef enum logic [1:0] {
		FILL_NONE  = 2'd0,                          // not enabled
		FILL_MUON  = 2'd1,
		FILL_LASER = 2'd2,
		FILL_PED   = 2'd3                           // pedestal
	} fill_type_t;

	// channel configuration, register block to acquisition
	typedef struct packed {
		logic [TAG_W-1:0]   channel_tag;
		logic [BURST_W-1:0] muon_bursts;
		logic [BURST_W-1:0] laser_bursts;
		logic [BURST_W-1:0] ped_bursts;
	} acq_cfg_t;

	localparam int HDR_PAD_W = WORD_W - MARK_W - CH_ADDR_W - 2 - BURST_W - TAG_W - FILL_NUM_W;

	// header word, always at buffer address 0
	typedef struct packed {
		logic [MARK_W-1:0]     mark;
		logic [HDR_PAD_W-1:0]  pad;                 // zero
		logic [CH_ADDR_W-1:0]  ch_addr;
		fill_type_t            fill_type;
		logic [BURST_W-1:0]    burst_cnt;
		logic [TAG_W-1:0]      channel_tag;
		logic [FILL_NUM_W-1:0] fill_num;
	} fill_header_t;

	// lane 0 holds the earliest sample, in the low bits
	typedef logic [LANES-1:0][LANE_W-1:0] burst_t;

	// address 0 reads as a header, every other address as a burst
	typedef union packed {
		fill_header_t hdr;
		burst_t       burst;
	} fill_word_u;

	// buffer write port
	typedef struct packed {
		logic                   en;
		logic [FILL_ADDR_W-1:0] addr;
		fill_word_u             data;
	} buf_wr_t;

endpackage
